//--- wd_fdc_top.f
hdl/wd_fdc_pkg.sv
hdl/wd_fdc_host_if.sv
hdl/wd_fdc_timer.sv
hdl/wd_fdc_geometry.sv
hdl/wd_fdc_cmd_fsm.sv
hdl/wd_fdc_top.sv
verif/wd_fdc_clk_gen.sv
verif/wd_fdc_chk.sv
verif/wd_fdc_tb.sv

//--- verif/wd_fdc_tb.sv
// Testbench for the WD1793-style FDC core
// random head moves and sector transfers against a disk image model,
// plus write protect, lost data, force interrupt and not ready

module wd_fdc_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int WATCHDOG   = 200;
	localparam int WAIT_LIMIT = 2000;
	localparam int EV_INTRQ   = 0;
	localparam int EV_DRQ     = 1;  // drq or intrq
	localparam int EV_DRQ_LOW = 2;
	localparam int EV_RESET   = 3;

	logic        clk_sys, rst_n;
	logic        io_en, rd, wr, wp, ready, side;
	logic [1:0]  addr;
	logic [7:0]  din, dout, img_wdata, img_rdata;
	logic [2:0]  size_code;
	logic        drq, intrq, busy, img_rd, img_wr;
	logic [19:0] img_addr;

	logic [7:0] img_mem [0:1048575];  // 1 MB disk image
	logic [7:0] wr_bytes [$];
	int seed = 61;
	int errors = 0;
	int img_wr_count = 0;
	int head, trk, step_out;  // model head, track register, direction
	int cur_code, cur_side;

	wd_fdc_clk_gen u_clk_gen (.clk_sys, .rst_n);

	wd_fdc_top #(
		.SEEK_CYCLES(20), .SETTLE_CYCLES(40), .BYTE_CYCLES(3), .WATCHDOG_CYCLES(WATCHDOG)
	) uut (
		.clk_sys, .rst_n, .io_en, .rd, .wr, .addr, .din, .dout, .drq, .intrq, .busy,
		.wp, .ready, .side, .size_code, .img_addr, .img_rd, .img_wr, .img_wdata, .img_rdata
	);

	assign img_rdata = img_mem[img_addr];

	always @(posedge clk_sys) begin
		if (img_wr) begin
			img_mem[img_addr] <= img_wdata;
			img_wr_count      <= img_wr_count + 1;
		end
	end

	// ========================================================================
	// reference geometry
	// ========================================================================
	function automatic int spt_of(input int code);
		case (code)
			1: return 16;
			2: return 9;
			3: return 5;
			4: return 10;
			5: return 18;
			default: return 26;
		endcase
	endfunction

	function automatic int len_of(input int code);
		case (code)
			1, 5: return 256;
			2, 4: return 512;
			3: return 1024;
			default: return 128;
		endcase
	endfunction

	function automatic int byte_addr(input int sec, input int idx);
		int lba;
		lba = (head * 2 + cur_side) * spt_of(cur_code) + sec - 1;
		return (lba * len_of(cur_code) + idx) & 20'hfffff;
	endfunction

	function automatic bit event_seen(input int kind);
		case (kind)
			EV_INTRQ:   return intrq;
			EV_DRQ:     return drq | intrq;
			EV_DRQ_LOW: return !drq;
			default:    return rst_n;
		endcase
	endfunction

	// ========================================================================
	// checks and waits
	// ========================================================================
	task automatic check_val(input string name, input int got, input int expected);
		if (got !== expected) begin
			errors++;
			$display("FAIL at %0t ns: %s = %0h, expected %0h", $time, name, got, expected);
			$display("Something failed");
			$fatal(1);
		end
	endtask

	task automatic abort_run(input string what);
		errors++;
		$display("at %0t ns: %s", $time, what);
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic wait_event(input int kind, input int limit, input string what);
		int n;
		n = 0;
		do begin
			@(negedge clk_sys);  // sample between edges
			n++;
		end while (!event_seen(kind) && n < limit);
		if (!event_seen(kind))
			abort_run({"timed out waiting for ", what});
	endtask

	task automatic bus_write(input logic [1:0] a, input logic [7:0] d);
		@(posedge clk_sys);
		io_en <= 1'b1;
		wr    <= 1'b1;
		addr  <= a;
		din   <= d;
		repeat (2) @(posedge clk_sys);
		io_en <= 1'b0;
		wr    <= 1'b0;
	endtask

	task automatic bus_read(input logic [1:0] a, output logic [7:0] d);
		@(posedge clk_sys);
		io_en <= 1'b1;
		rd    <= 1'b1;
		addr  <= a;
		@(posedge clk_sys);
		@(negedge clk_sys);
		d = dout;
		@(posedge clk_sys);
		io_en <= 1'b0;
		rd    <= 1'b0;
	endtask

	task automatic set_geometry(input int code, input int sd);
		@(posedge clk_sys);
		size_code <= 3'(code);
		side      <= sd[0];
		cur_code = code;
		cur_side = sd & 1;
	endtask

	// restore, seek or step, then track register and type I status
	task automatic head_cmd(input logic [7:0] cmd, input int dst);
		logic [7:0] v;
		if (cmd[7:4] == 4'h1)
			bus_write(3, 8'(dst));  // seek target goes through the data register
		bus_write(0, cmd);
		if (cmd[7:4] == 4'h0) begin
			head = 0;
			trk  = 0;
		end else if (cmd[7:4] == 4'h1) begin
			head = dst;
			trk  = dst;
		end else begin
			if (cmd[6])
				step_out = cmd[5];
			head = step_out ? (head - 1) & 8'hff : (head + 1) & 8'hff;
			if (cmd[4])
				trk = head;
		end
		wait_event(EV_INTRQ, WAIT_LIMIT, "intrq after a head command");
		check_val("busy", busy, 0);
		bus_read(1, v);
		check_val("track", v, trk);
		bus_read(0, v);
		check_val("status", v, {2'b00, cmd[3], cmd[2] && trk != head, 1'b0, head == 0, 2'b00});
	endtask

	task automatic read_sectors(input int sec, input bit multi, input bit skip_first,
	                            output int count);
		logic [7:0] b;
		int idx;
		bit skip, done;
		idx   = 0;
		count = 0;
		skip  = skip_first;
		done  = 0;
		bus_write(2, 8'(sec));
		bus_write(0, multi ? 8'h90 : 8'h80);
		while (!done) begin
			wait_event(EV_DRQ, WAIT_LIMIT, "drq in a sector read");
			if (intrq) begin
				done = 1;
			end else begin
				if (skip) begin
					skip = 0;  // left for the watchdog
				end else begin
					bus_read(3, b);
					check_val("read data", b, img_mem[byte_addr(sec, idx)]);
					count++;
					@(negedge clk_sys);
					check_val("img_rd", img_rd, 1);  // port still owned by the read
				end
				wait_event(EV_DRQ_LOW, 2 * WATCHDOG, "drq to drop");
				idx++;
				if (idx == len_of(cur_code)) begin
					idx = 0;
					sec++;
				end
			end
		end
	endtask

	task automatic write_sector(input int sec);
		logic [7:0] b;
		bit done;
		done = 0;
		wr_bytes.delete();
		bus_write(2, 8'(sec));
		bus_write(0, 8'ha0);
		while (!done) begin
			wait_event(EV_DRQ, WAIT_LIMIT, "drq in a sector write");
			if (intrq) begin
				done = 1;
			end else begin
				b = 8'($random(seed));
				bus_write(3, b);
				wr_bytes.push_back(b);
				wait_event(EV_DRQ_LOW, 2 * WATCHDOG, "drq to drop");
				check_val("img_rd", img_rd, 0);
			end
		end
		check_val("bytes written", wr_bytes.size(), len_of(cur_code));
		foreach (wr_bytes[i])
			check_val("image byte", img_mem[byte_addr(sec, i)], wr_bytes[i]);
	endtask

	// ========================================================================
	// test sequence
	// ========================================================================
	initial begin
		logic [7:0] v;
		int n, sec, spt, wr_before;
		io_en     = 1'b0;
		rd        = 1'b0;
		wr        = 1'b0;
		addr      = 2'd0;
		din       = 8'd0;
		wp        = 1'b0;
		ready     = 1'b1;
		side      = 1'b0;
		size_code = 3'd0;
		step_out  = 0;
		cur_code  = 0;
		cur_side  = 0;
		for (int i = 0; i < 1048576; i++)
			img_mem[i] = 8'($random(seed));

		wait_event(EV_RESET, 20, "reset release");
		check_val("busy", busy, 0);
		check_val("drq", drq, 0);
		check_val("intrq", intrq, 0);
		bus_read(1, v);
		check_val("track", v, 0);
		bus_read(2, v);
		check_val("sector", v, 0);

		head_cmd(8'h08, 0);  // restore, head loaded
		repeat (12) begin
			case ($unsigned($random(seed)) % 4)
				0: v = 8'h10;
				1: v = 8'h20;
				2: v = 8'h40;
				default: v = 8'h60;
			endcase
			v = v | (8'($random(seed)) & 8'h1c);  // update, head load, verify
			head_cmd(v, $unsigned($random(seed)) % 40);
		end

		// single sector reads over random geometries
		repeat (4) begin
			set_geometry($unsigned($random(seed)) % 6, $random(seed));
			head_cmd(8'h18, $unsigned($random(seed)) % 40);
			sec = 1 + $unsigned($random(seed)) % spt_of(cur_code);
			read_sectors(sec, 0, 0, n);
			check_val("bytes read", n, len_of(cur_code));
			bus_read(0, v);
			check_val("status", v, 8'h00);
		end

		// multi sector read runs off the end of the track
		set_geometry($unsigned($random(seed)) % 6, $random(seed));
		head_cmd(8'h18, $unsigned($random(seed)) % 40);
		spt = spt_of(cur_code);
		sec = spt - $unsigned($random(seed)) % 3;
		read_sectors(sec, 1, 0, n);
		check_val("bytes read", n, (spt - sec + 1) * len_of(cur_code));
		bus_read(2, v);
		check_val("sector", v, spt + 1);
		bus_read(0, v);
		check_val("status", v, 8'h10);

		sec = 1 + $unsigned($random(seed)) % spt;
		write_sector(sec);
		bus_read(0, v);
		check_val("status", v, 8'h00);
		read_sectors(sec, 0, 0, n);
		check_val("bytes read", n, len_of(cur_code));

		// protected disk
		@(posedge clk_sys);
		wp <= 1'b1;
		wr_before = img_wr_count;
		bus_write(0, 8'ha0);
		wait_event(EV_DRQ, WAIT_LIMIT, "end of a protected write");
		if (!intrq) begin
			bus_write(3, 8'h5a);  // a byte offered anyway must not reach the image
			@(negedge clk_sys);
		end
		check_val("img_wr pulses", img_wr_count, wr_before);
		wait_event(EV_INTRQ, WAIT_LIMIT, "intrq after a protected write");
		bus_read(0, v);
		check_val("status", v, 8'h60);
		@(posedge clk_sys);
		wp <= 1'b0;

		read_sectors(sec, 0, 1, n);  // first byte times out
		check_val("bytes read", n, len_of(cur_code) - 1);
		bus_read(0, v);
		check_val("status", v, 8'h04);

		bus_write(0, 8'h80);
		wait_event(EV_DRQ, WAIT_LIMIT, "drq before force interrupt");
		bus_write(0, 8'hd0);
		wait_event(EV_INTRQ, WAIT_LIMIT, "intrq after force interrupt");
		check_val("busy", busy, 0);
		check_val("drq", drq, 0);
		bus_read(0, v);
		check_val("status busy bit", v[0], 0);

		@(posedge clk_sys);
		ready <= 1'b0;
		bus_write(0, 8'h80);
		wait_event(EV_INTRQ, WAIT_LIMIT, "intrq with the drive not ready");
		bus_read(0, v);
		check_val("status", v, 8'h90);
		@(posedge clk_sys);
		ready <= 1'b1;

		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

//--- verif/wd_fdc_chk.sv
// FDC handshake checker
// concurrent assertions on drq, busy, intrq and image writes,
// bound into the controller top level

module wd_fdc_chk
	import wd_fdc_pkg::*;
(
	input logic       clk_sys,
	input logic       rst_n,
	input logic       drq,
	input logic       busy,
	input logic       intrq,
	input logic       img_wr,
	input fdc_state_t state
);
	timeunit 1ns;
	timeprecision 100ps;

	a_drq_busy: assert property (@(posedge clk_sys) disable iff (!rst_n) drq |-> busy)
		else $error("drq high while the controller is not busy");

	// image writes only while a write command waits for its byte
	a_img_wr: assert property (@(posedge clk_sys) disable iff (!rst_n)
		img_wr |-> state == ST_WRITE_WAIT)
		else $error("image write outside a write transfer");

	a_intrq_end: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$rose(intrq) |-> $fell(busy))
		else $error("intrq rose while busy did not fall");

	a_idle: assert property (@(posedge clk_sys) disable iff (!rst_n)
		state == ST_IDLE |-> !busy)
		else $error("busy high in the idle state");

endmodule

bind wd_fdc_top wd_fdc_chk u_chk (
	.clk_sys, .rst_n, .drq, .busy, .intrq, .img_wr, .state(u_cmd_fsm.state)
);

//--- verif/wd_fdc_clk_gen.sv
// Testbench clock and reset
// 20 ns clock, reset held low for the first 5 cycles

module wd_fdc_clk_gen (
	output logic clk_sys,
	output logic rst_n
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	initial begin
		rst_n = 1'b0;
		repeat (5) @(posedge clk_sys);
		rst_n <= 1'b1;  // released on a rising edge
	end

endmodule

//--- hdl/wd_fdc_top.sv
// WD1793-style floppy disk controller core
// host strobe bus in front, byte-addressed disk image memory behind

module wd_fdc_top
	import wd_fdc_pkg::*;
#(
	parameter int SEEK_CYCLES     = 1023,
	parameter int SETTLE_CYCLES   = 4000,
	parameter int BYTE_CYCLES     = 15,
	parameter int WATCHDOG_CYCLES = 4096
) (
	input  logic        clk_sys,
	input  logic        rst_n,
	input  logic        io_en,
	input  logic        rd,
	input  logic        wr,
	input  logic [1:0]  addr,
	input  logic [7:0]  din,
	output logic [7:0]  dout,
	output logic        drq,
	output logic        intrq,
	output logic        busy,
	input  logic        wp,
	input  logic        ready,
	input  logic        side,
	input  logic [2:0]  size_code,
	output logic [19:0] img_addr,
	output logic        img_rd,
	output logic        img_wr,
	output logic [7:0]  img_wdata,
	input  logic [7:0]  img_rdata
);

	logic        cmd_wr_evt, trk_wr_evt, sec_wr_evt, data_wr_evt;
	logic        data_rd_done, status_rd_done;
	logic [7:0]  track_reg, sector_reg, disk_track;
	logic [5:0]  status_flags;
	logic        type2_mode;
	logic        rd_active;
	logic        timer_load, timer_done;
	timer_kind_t timer_kind;
	sector_len_t byte_idx, sector_len;
	logic [7:0]  sectors_per_track;

	assign img_rd = rd_active & (addr == A_DATA);

	// wr_byte doubles as the image write data
	wd_fdc_host_if u_host_if (
		.clk_sys, .rst_n, .io_en, .rd, .wr, .addr(reg_addr_t'(addr)), .din,
		.track_reg, .sector_reg, .disk_track, .status_flags, .type2_mode,
		.drq, .busy, .ready, .wp, .rd_active, .img_rdata, .dout,
		.cmd_wr_evt, .trk_wr_evt, .sec_wr_evt, .data_wr_evt, .data_rd_done,
		.status_rd_done, .wr_byte(img_wdata)
	);

	wd_fdc_timer #(
		.SEEK_CYCLES(SEEK_CYCLES), .SETTLE_CYCLES(SETTLE_CYCLES),
		.BYTE_CYCLES(BYTE_CYCLES), .WATCHDOG_CYCLES(WATCHDOG_CYCLES)
	) u_timer (
		.clk_sys, .rst_n, .timer_load, .timer_kind, .timer_done
	);

	wd_fdc_geometry u_geometry (
		.clk_sys, .rst_n, .size_code, .disk_track, .side, .sector_reg, .byte_idx,
		.img_addr, .sector_len, .sectors_per_track
	);

	wd_fdc_cmd_fsm u_cmd_fsm (
		.clk_sys, .rst_n, .cmd_wr_evt, .trk_wr_evt, .sec_wr_evt, .data_wr_evt,
		.data_rd_done, .status_rd_done, .wr_byte(img_wdata), .ready, .wp,
		.timer_done, .sector_len, .sectors_per_track, .track_reg, .sector_reg,
		.disk_track, .status_flags, .type2_mode, .drq, .busy, .intrq, .rd_active,
		.wr_active(), .byte_idx, .timer_load, .timer_kind, .img_wr
	);

endmodule

//--- hdl/wd_fdc_cmd_fsm.sv
// FDC command sequencer
// decodes commands, moves the head, runs the per-byte drq/watchdog
// loop for sector reads and writes and keeps the status flags

module wd_fdc_cmd_fsm
	import wd_fdc_pkg::*;
(
	input  logic        clk_sys,
	input  logic        rst_n,
	input  logic        cmd_wr_evt,
	input  logic        trk_wr_evt,
	input  logic        sec_wr_evt,
	input  logic        data_wr_evt,
	input  logic        data_rd_done,
	input  logic        status_rd_done,
	input  logic [7:0]  wr_byte,
	input  logic        ready,
	input  logic        wp,
	input  logic        timer_done,
	input  sector_len_t sector_len,
	input  logic [7:0]  sectors_per_track,
	output logic [7:0]  track_reg,
	output logic [7:0]  sector_reg,
	output logic [7:0]  disk_track,  // real head position
	output logic [5:0]  status_flags,
	output logic        type2_mode,
	output logic        drq,
	output logic        busy,
	output logic        intrq,
	output logic        rd_active,
	output logic        wr_active,
	output sector_len_t byte_idx,
	output logic        timer_load,
	output timer_kind_t timer_kind,
	output logic        img_wr
);

	fdc_state_t state;
	cmd_code_t  cmd_code;
	logic       step_dir;  // 1 = out, towards track 0
	logic       multi;
	logic       verify;
	logic [7:0] seek_dst;  // copy of the data register for SEEK
	logic       wp_en, head_loaded, seek_err, rnf, wr_fault, lost_data;
	logic [7:0] next_track;
	logic       tmr_expired;
	logic       xfer_evt;
	logic       last_byte;

	assign cmd_code     = cmd_code_t'(wr_byte[7:4]);
	assign next_track   = (wr_byte[6] ? wr_byte[5] : step_dir) ? disk_track - 8'd1 :
	                                                             disk_track + 8'd1;
	assign tmr_expired  = timer_done & ~timer_load;  // ignore the count until it is loaded
	assign xfer_evt     = rd_active ? data_rd_done : data_wr_evt;
	assign last_byte    = (byte_idx == sector_len - 11'd1);
	assign status_flags = {wp_en, head_loaded, seek_err, rnf, wr_fault, lost_data};
	assign img_wr       = data_wr_evt & wr_active & drq;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state       <= ST_IDLE;
			track_reg   <= 8'd0;
			sector_reg  <= 8'd0;
			disk_track  <= 8'd0;
			seek_dst    <= 8'd0;
			step_dir    <= 1'b0;
			multi       <= 1'b0;
			verify      <= 1'b0;
			{wp_en, head_loaded, seek_err, rnf, wr_fault, lost_data} <= '0;
			type2_mode  <= 1'b0;
			drq         <= 1'b0;
			busy        <= 1'b0;
			intrq       <= 1'b0;
			rd_active   <= 1'b0;
			wr_active   <= 1'b0;
			byte_idx    <= '0;
			timer_load  <= 1'b0;
			timer_kind  <= TMR_SEEK;
		end else begin
			timer_load <= 1'b0;
			if (status_rd_done)
				intrq <= 1'b0;
			if (data_wr_evt)
				seek_dst <= wr_byte;
			if (trk_wr_evt && !busy)
				track_reg <= wr_byte;
			if (sec_wr_evt && !busy)
				sector_reg <= wr_byte;

			case (state)
				ST_IDLE: ;
				ST_SEARCH: begin
					if (!ready) begin
						rnf   <= 1'b1;
						state <= ST_END_CMD;
					end else if (tmr_expired) begin
						byte_idx <= '0;
						if (sector_reg == 8'd0 || sector_reg > sectors_per_track) begin
							rnf   <= 1'b1;  // record not found
							state <= ST_END_CMD;
						end else begin
							timer_load <= 1'b1;
							timer_kind <= TMR_BYTE;
							state      <= wr_active ? ST_WRITE_ARM : ST_READ_ARM;
						end
					end
				end
				// byte spacing, then offer the byte
				ST_READ_ARM, ST_WRITE_ARM: begin
					if (tmr_expired) begin
						drq        <= 1'b1;
						timer_load <= 1'b1;
						timer_kind <= TMR_WATCHDOG;
						state      <= (state == ST_READ_ARM) ? ST_READ_WAIT : ST_WRITE_WAIT;
					end
				end
				ST_READ_WAIT, ST_WRITE_WAIT: begin
					if (xfer_evt || tmr_expired) begin
						drq <= 1'b0;
						if (!xfer_evt)
							lost_data <= 1'b1;  // host too slow, byte skipped
						if (!last_byte) begin
							byte_idx   <= byte_idx + 11'd1;
							timer_load <= 1'b1;
							timer_kind <= TMR_BYTE;
							state <= (state == ST_READ_WAIT) ? ST_READ_ARM : ST_WRITE_ARM;
						end else if (multi) begin
							sector_reg <= sector_reg + 8'd1;  // runs off the track end
							timer_load <= 1'b1;
							timer_kind <= TMR_SEEK;
							state      <= ST_SEARCH;
						end else begin
							state <= ST_END_CMD;
						end
					end
				end
				ST_SETTLE: begin
					if (tmr_expired) begin
						// verify compares the track register with the head
						if (!type2_mode && verify && (!ready || track_reg != disk_track))
							seek_err <= 1'b1;
						state <= ST_END_CMD;
					end
				end
				ST_ABORT: begin
					{seek_err, rnf, wr_fault, lost_data} <= '0;
					state <= ST_END_CMD;
				end
				ST_END_CMD: begin
					busy      <= 1'b0;
					drq       <= 1'b0;
					rd_active <= 1'b0;
					wr_active <= 1'b0;
					intrq     <= 1'b1;
					state     <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase

			// ================================================================
			// command decode, only force interrupt gets through while busy
			// ================================================================
			if (cmd_wr_evt) begin
				intrq <= 1'b0;
				if (state == ST_IDLE || cmd_code == CMD_FORCE_INT) begin
					type2_mode <= wr_byte[7];
					wp_en      <= ~wr_byte[7];
					case (cmd_code)
						CMD_RESTORE, CMD_SEEK, CMD_STEP, CMD_STEP_U, CMD_STEP_IN,
						CMD_STEP_IN_U, CMD_STEP_OUT, CMD_STEP_OUT_U: begin
							busy        <= 1'b1;
							head_loaded <= wr_byte[3];
							verify      <= wr_byte[2];
							seek_err    <= 1'b0;
							timer_load  <= 1'b1;
							timer_kind  <= TMR_SETTLE;
							state       <= ST_SETTLE;
							if (cmd_code == CMD_RESTORE) begin
								track_reg  <= 8'd0;
								disk_track <= 8'd0;
							end else if (cmd_code == CMD_SEEK) begin
								track_reg  <= seek_dst;
								disk_track <= seek_dst;
							end else begin
								if (wr_byte[6])
									step_dir <= wr_byte[5];  // in/out sets direction
								disk_track <= next_track;
								if (wr_byte[4])
									track_reg <= next_track;
							end
						end
						CMD_READ, CMD_READ_M, CMD_WRITE, CMD_WRITE_M: begin
							busy       <= 1'b1;
							{seek_err, rnf, wr_fault, lost_data} <= '0;
							multi      <= wr_byte[4];
							wp_en      <= wr_byte[5];
							timer_load <= 1'b1;
							if (wr_byte[5] && wp) begin
								wr_fault   <= 1'b1;  // protected disk, no transfer
								timer_kind <= TMR_SETTLE;
								state      <= ST_SETTLE;
							end else begin
								rd_active  <= ~wr_byte[5];
								wr_active  <= wr_byte[5];
								timer_kind <= TMR_SEEK;
								state      <= ST_SEARCH;
							end
						end
						CMD_FORCE_INT: begin
							type2_mode <= 1'b0;
							if (state != ST_IDLE)
								state <= ST_ABORT;
							else
								{seek_err, rnf, wr_fault, lost_data} <= '0;
						end
						CMD_READ_ADDR, CMD_READ_TRK, CMD_WRITE_TRK: begin
							// busy for a while, no data moves
							busy       <= 1'b1;
							{seek_err, wr_fault, lost_data} <= '0;
							rnf        <= (cmd_code == CMD_READ_TRK);
							wp_en      <= (cmd_code == CMD_WRITE_TRK);
							timer_load <= 1'b1;
							timer_kind <= TMR_SETTLE;
							state      <= ST_SETTLE;
						end
					endcase
				end
			end
		end
	end

endmodule

//--- hdl/wd_fdc_geometry.sv
// FDC disk geometry
// looks up sector size and sectors per track for the size code and
// turns track, side, sector and byte index into an image byte address

module wd_fdc_geometry
	import wd_fdc_pkg::*;
(
	input  logic        clk_sys,
	input  logic        rst_n,
	input  logic [2:0]  size_code,
	input  logic [7:0]  disk_track,
	input  logic        side,
	input  logic [7:0]  sector_reg,
	input  sector_len_t byte_idx,
	output img_addr_t   img_addr,
	output sector_len_t sector_len,
	output logic [7:0]  sectors_per_track
);

	logic [1:0]  len_code;
	logic [7:0]  spt;
	logic [8:0]  trk_side;  // track * 2 + side
	logic [16:0] trk_base;  // first sector number of this track side
	logic [16:0] lba;
	logic [27:0] sec_base;

	// ========================================================================
	// address arithmetic
	// ========================================================================
	always_comb begin
		len_code = geo_len_code(size_code);
		spt      = geo_spt(size_code);
		trk_side = {disk_track, side};
		trk_base = trk_side * spt;
		lba      = trk_base + {9'd0, sector_reg} - 17'd1;  // sectors count from 1
		sec_base = ({11'd0, lba} << 7) << len_code;
	end

	// image is at most 1 MB, upper bits drop out
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			img_addr          <= '0;
			sector_len        <= 11'd128;
			sectors_per_track <= 8'd26;
		end else begin
			img_addr          <= sec_base[19:0] + {9'd0, byte_idx};
			sector_len        <= 11'd128 << len_code;
			sectors_per_track <= spt;
		end
	end

endmodule

//--- hdl/wd_fdc_timer.sv
// FDC delay timer
// one 16-bit down counter shared by the seek, settle, byte spacing
// and watchdog delays, since only one of them runs at a time

module wd_fdc_timer
	import wd_fdc_pkg::*;
#(
	parameter int SEEK_CYCLES     = 1023,
	parameter int SETTLE_CYCLES   = 4000,
	parameter int BYTE_CYCLES     = 15,
	parameter int WATCHDOG_CYCLES = 4096
) (
	input  logic        clk_sys,
	input  logic        rst_n,
	input  logic        timer_load,
	input  timer_kind_t timer_kind,
	output logic        timer_done
);

	logic [15:0] count;
	logic [15:0] load_val;

	always_comb begin
		case (timer_kind)
			TMR_SEEK:     load_val = 16'(SEEK_CYCLES);
			TMR_SETTLE:   load_val = 16'(SETTLE_CYCLES);
			TMR_BYTE:     load_val = 16'(BYTE_CYCLES);
			default:      load_val = 16'(WATCHDOG_CYCLES);
		endcase
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			count <= 16'd0;
		end else if (timer_load) begin
			count <= load_val;
		end else if (count != 16'd0) begin
			count <= count - 16'd1;  // stops at zero
		end
	end

	// also high while idle
	assign timer_done = (count == 16'd0);

endmodule

//--- hdl/wd_fdc_host_if.sv
// Host bus interface of the FDC
// turns io strobes into one-cycle events, keeps the data register
// and builds the status byte for the read-back mux

module wd_fdc_host_if
	import wd_fdc_pkg::*;
(
	input  logic       clk_sys,
	input  logic       rst_n,
	input  logic       io_en,
	input  logic       rd,
	input  logic       wr,
	input  reg_addr_t  addr,
	input  logic [7:0] din,
	input  logic [7:0] track_reg,
	input  logic [7:0] sector_reg,
	input  logic [7:0] disk_track,
	input  logic [5:0] status_flags,  // wpe, hld, seek err, rnf, wr fault, lost
	input  logic       type2_mode,
	input  logic       drq,
	input  logic       busy,
	input  logic       ready,
	input  logic       wp,
	input  logic       rd_active,
	input  logic [7:0] img_rdata,
	output logic [7:0] dout,
	output logic       cmd_wr_evt,
	output logic       trk_wr_evt,
	output logic       sec_wr_evt,
	output logic       data_wr_evt,
	output logic       data_rd_done,
	output logic       status_rd_done,
	output logic [7:0] wr_byte
);

	logic       rd_q, wr_q;
	logic       rde, wre;
	logic       rd_rise, rd_fall, wr_rise;
	reg_addr_t  cur_addr;  // address of the access in progress
	logic [7:0] data_reg;
	logic [7:0] status;

	assign rde     = io_en & rd;
	assign wre     = io_en & wr;
	assign rd_rise = rde & ~rd_q;
	assign rd_fall = rd_q & ~rde;
	assign wr_rise = wre & ~wr_q;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			rd_q           <= 1'b0;
			wr_q           <= 1'b0;
			cur_addr       <= A_STATUS;
			data_reg       <= 8'd0;
			cmd_wr_evt     <= 1'b0;
			trk_wr_evt     <= 1'b0;
			sec_wr_evt     <= 1'b0;
			data_wr_evt    <= 1'b0;
			data_rd_done   <= 1'b0;
			status_rd_done <= 1'b0;
		end else begin
			rd_q <= rde;
			wr_q <= wre;
			if (rd_rise || wr_rise)
				cur_addr <= addr;
			if (wr_rise && addr == A_DATA)
				data_reg <= din;
			cmd_wr_evt     <= wr_rise && addr == A_STATUS;
			trk_wr_evt     <= wr_rise && addr == A_TRACK;
			sec_wr_evt     <= wr_rise && addr == A_SECTOR;
			data_wr_evt    <= wr_rise && addr == A_DATA;
			data_rd_done   <= rd_fall && cur_addr == A_DATA;    // byte taken by host
			status_rd_done <= rd_fall && cur_addr == A_STATUS;  // clears intrq
		end
	end

	// byte of the last write, valid while its event pulses
	always_ff @(posedge clk_sys) begin
		if (wr_rise)
			wr_byte <= din;
	end

	// crc error and index are always 0
	assign status = type2_mode ?
		{~ready, wp & status_flags[5], status_flags[1], status_flags[2] | ~ready,
		 1'b0, status_flags[0], drq, busy} :
		{~ready, wp & status_flags[5], status_flags[4], status_flags[3] | ~ready,
		 1'b0, disk_track == 8'd0, 1'b0, busy};

	always_comb begin
		case (addr)
			A_STATUS: dout = status;
			A_TRACK:  dout = track_reg;
			A_SECTOR: dout = sector_reg;
			default:  dout = rd_active ? img_rdata : data_reg;  // image during reads
		endcase
	end

endmodule

//--- hdl/wd_fdc_pkg.sv
// WD1793-style floppy disk controller, shared definitions
// register map, command codes, FSM states and the fixed disk geometries

package wd_fdc_pkg;

	typedef enum logic [1:0] {
		A_STATUS = 2'd0,  // status on read, command on write
		A_TRACK  = 2'd1,
		A_SECTOR = 2'd2,
		A_DATA   = 2'd3
	} reg_addr_t;

	// high nibble of the command byte
	typedef enum logic [3:0] {
		CMD_RESTORE    = 4'h0, CMD_SEEK       = 4'h1,
		CMD_STEP       = 4'h2, CMD_STEP_U     = 4'h3,
		CMD_STEP_IN    = 4'h4, CMD_STEP_IN_U  = 4'h5,
		CMD_STEP_OUT   = 4'h6, CMD_STEP_OUT_U = 4'h7,
		CMD_READ       = 4'h8, CMD_READ_M     = 4'h9,
		CMD_WRITE      = 4'hA, CMD_WRITE_M    = 4'hB,
		CMD_READ_ADDR  = 4'hC, CMD_FORCE_INT  = 4'hD,
		CMD_READ_TRK   = 4'hE, CMD_WRITE_TRK  = 4'hF
	} cmd_code_t;

	typedef enum logic [3:0] {
		ST_IDLE, ST_SEARCH, ST_READ_ARM, ST_READ_WAIT, ST_WRITE_ARM,
		ST_WRITE_WAIT, ST_ABORT, ST_SETTLE, ST_END_CMD
	} fdc_state_t;

	typedef enum logic [1:0] {TMR_SEEK, TMR_SETTLE, TMR_BYTE, TMR_WATCHDOG} timer_kind_t;

	typedef logic [19:0] img_addr_t;    // byte address into the disk image
	typedef logic [10:0] sector_len_t;  // up to 1024 bytes

	// ========================================================================
	// geometry tables, codes 6 and 7 fall back to code 0
	// ========================================================================
	function automatic logic [7:0] geo_spt(input logic [2:0] size_code);
		case (size_code)
			3'd1:    return 8'd16;
			3'd2:    return 8'd9;
			3'd3:    return 8'd5;
			3'd4:    return 8'd10;
			3'd5:    return 8'd18;
			default: return 8'd26;
		endcase
	endfunction

	// sector length is 128 << code
	function automatic logic [1:0] geo_len_code(input logic [2:0] size_code);
		case (size_code)
			3'd1, 3'd5: return 2'd1;
			3'd2, 3'd4: return 2'd2;
			3'd3:       return 2'd3;
			default:    return 2'd0;
		endcase
	endfunction

endpackage
